//--- letc_core_defs.svh
`ifndef LETC_CORE_DEFS_SVH
`define LETC_CORE_DEFS_SVH

//Width of one data word and of the instruction word
`define LETC_XLEN 32

//Bits needed to name one architectural register
`define LETC_REG_IDX_W 5

//Architectural registers including the hardwired x0
`define LETC_NUM_REGS 32

//F1 F2 D E1 E2 W
//Also the width of the stall, flush and valid vectors
`define LETC_NUM_STAGES 6

//Width of the sign-extended I-type immediate field
`define LETC_IMM_W 12

`endif

//--- letc_core_pkg.sv
`include "letc_core_defs.svh"

package letc_core_pkg;

//Basic data types
typedef logic [`LETC_XLEN-1:0]      word_t;
typedef logic [`LETC_REG_IDX_W-1:0] reg_idx_t;

//Major opcodes of the supported subset
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

//funct3 and funct7 encodings
localparam logic [2:0] F3_ADD_SUB = 3'b000;
localparam logic [2:0] F3_XOR     = 3'b100;
localparam logic [2:0] F3_OR      = 3'b110;
localparam logic [2:0] F3_AND     = 3'b111;
localparam logic [6:0] F7_BASE    = 7'b0000000;
localparam logic [6:0] F7_SUB     = 7'b0100000;

//Register-register layout
typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
} r_fmt_t;

//Register-immediate layout
typedef struct packed {
    logic [`LETC_IMM_W-1:0] imm;
    reg_idx_t               rs1;
    logic [2:0]             funct3;
    reg_idx_t               rd;
    logic [6:0]             opcode;
} i_fmt_t;

//Same instruction word seen through either layout
typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
} insn_u;

//Operation handed from D to E1
typedef enum logic [2:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
} alu_op_e;

//Bit positions in the per-stage vectors
typedef enum logic [2:0] {
    STAGE_F1 = 3'd0,
    STAGE_F2 = 3'd1,
    STAGE_D  = 3'd2,
    STAGE_E1 = 3'd3,
    STAGE_E2 = 3'd4,
    STAGE_W  = 3'd5
} stage_e;

endpackage : letc_core_pkg

//--- letc_core_rf.sv
`include "letc_core_defs.svh"

module letc_core_rf (
    //Clock and reset
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    //Read ports
    input  letc_core_pkg::reg_idx_t i_rs1_idx,
    input  letc_core_pkg::reg_idx_t i_rs2_idx,
    output letc_core_pkg::word_t    o_rs1_rdata,
    output letc_core_pkg::word_t    o_rs2_rdata,

    //Write port, driven from W on retire
    input  logic                    i_wen,
    input  letc_core_pkg::reg_idx_t i_rd_idx,
    input  letc_core_pkg::word_t    i_rd_data
);

//x0 has no storage
letc_core_pkg::word_t regs [1:`LETC_NUM_REGS-1];

always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
        for (int ii = 1; ii < `LETC_NUM_REGS; ++ii) begin
            regs[ii] <= '0;
        end
    end else if (i_wen && (i_rd_idx != '0)) begin
        regs[i_rd_idx] <= i_rd_data;
    end
end

//Combinational reads
//A same-cycle write is covered by the W bypass, so no write-through here
assign o_rs1_rdata = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
assign o_rs2_rdata = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

endmodule : letc_core_rf

//--- letc_core_tghm.sv
`include "letc_core_defs.svh"

module letc_core_tghm (
    //Per-stage occupancy and the retire port's back-pressure
    input  logic [`LETC_NUM_STAGES-1:0] i_stage_valid,
    input  logic                        i_wb_ready,

    //Source indices in D, already zero when not read
    input  letc_core_pkg::reg_idx_t     i_d_rs1_idx,
    input  letc_core_pkg::reg_idx_t     i_d_rs2_idx,

    //Destinations downstream, already zero when nothing is written
    input  letc_core_pkg::reg_idx_t     i_e1_rd_idx,
    input  letc_core_pkg::reg_idx_t     i_e2_rd_idx,
    input  letc_core_pkg::reg_idx_t     i_w_rd_idx,
    input  letc_core_pkg::word_t        i_e2_rd_data,
    input  letc_core_pkg::word_t        i_w_rd_data,

    //Stall and flush per stage
    output logic [`LETC_NUM_STAGES-1:0] o_stage_stall,
    output logic [`LETC_NUM_STAGES-1:0] o_stage_flush,

    //D operand overrides
    output logic                        o_stage_d_bypass_rs1,
    output logic                        o_stage_d_bypass_rs2,
    output letc_core_pkg::word_t        o_stage_d_bypass_rs1_rdata,
    output letc_core_pkg::word_t        o_stage_d_bypass_rs2_rdata
);

logic d_raw_hazard;
logic rs1_hit_e2;
logic rs1_hit_w;
logic rs2_hit_e2;
logic rs2_hit_w;

//E1 result is not ready until E2, so D has to wait one cycle
//A nonzero E1 rd implies E1 is valid, and a match implies a real source
assign d_raw_hazard = (i_e1_rd_idx != '0) &&
                      ((i_e1_rd_idx == i_d_rs1_idx) || (i_e1_rd_idx == i_d_rs2_idx));

//Stall chain built from W backwards
//Empty stages never stall, which lets bubbles be squeezed out
always_comb begin
    o_stage_stall[letc_core_pkg::STAGE_W] = i_stage_valid[letc_core_pkg::STAGE_W] && !i_wb_ready;
    for (int ii = int'(letc_core_pkg::STAGE_E2); ii >= 0; --ii) begin
        o_stage_stall[ii] = o_stage_stall[ii+1] && i_stage_valid[ii];
        //The hazard holds D and everything behind it
        if (ii == int'(letc_core_pkg::STAGE_D)) begin
            o_stage_stall[ii] = o_stage_stall[ii] || d_raw_hazard;
        end
    end
end

//E1 takes a bubble instead of the held D instruction
//Only when E1 advances, otherwise it keeps its own occupant
always_comb begin
    o_stage_flush = '0;
    o_stage_flush[letc_core_pkg::STAGE_E1] = d_raw_hazard &&
                                             !o_stage_stall[letc_core_pkg::STAGE_E1];
end

//Bypass match per source
assign rs1_hit_e2 = (i_d_rs1_idx != '0) && (i_d_rs1_idx == i_e2_rd_idx);
assign rs1_hit_w  = (i_d_rs1_idx != '0) && (i_d_rs1_idx == i_w_rd_idx);
assign rs2_hit_e2 = (i_d_rs2_idx != '0) && (i_d_rs2_idx == i_e2_rd_idx);
assign rs2_hit_w  = (i_d_rs2_idx != '0) && (i_d_rs2_idx == i_w_rd_idx);

//E2 is younger than W and wins
assign o_stage_d_bypass_rs1       = rs1_hit_e2 || rs1_hit_w;
assign o_stage_d_bypass_rs2       = rs2_hit_e2 || rs2_hit_w;
assign o_stage_d_bypass_rs1_rdata = rs1_hit_e2 ? i_e2_rd_data : i_w_rd_data;
assign o_stage_d_bypass_rs2_rdata = rs2_hit_e2 ? i_e2_rd_data : i_w_rd_data;

endmodule : letc_core_tghm

//--- letc_core_stage_f.sv
module letc_core_stage_f (
    //Clock and reset
    input  logic                 i_clk,
    input  logic                 i_rst_n,

    //Instruction input, ready is the inverse of the F1 stall
    input  logic                 i_insn_valid,
    input  letc_core_pkg::word_t i_insn,

    //Stalls from the hazard unit
    input  logic                 i_stall_f1,
    input  logic                 i_stall_f2,
    input  logic                 i_stall_d,

    //Slot state
    output logic                 o_f1_valid,
    output logic                 o_f2_valid,
    output letc_core_pkg::word_t o_f2_insn
);

letc_core_pkg::word_t f1_insn;
logic                 insn_xfer;
logic                 f1_to_f2;

//Handshake completes whenever F1 is free to load
assign insn_xfer = i_insn_valid && !i_stall_f1;

//F1 drains when F2 is empty or D is taking F2
assign f1_to_f2 = o_f1_valid && (!o_f2_valid || !i_stall_d);

//Control state
always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
        o_f1_valid <= 1'b0;
        o_f2_valid <= 1'b0;
    end else begin
        if (!i_stall_f1) begin
            o_f1_valid <= i_insn_valid;
        end
        if (!i_stall_f2) begin
            o_f2_valid <= f1_to_f2;
        end
    end
end

//Payload only moves with a real instruction
always_ff @(posedge i_clk) begin
    if (insn_xfer) begin
        f1_insn <= i_insn;
    end
    if (f1_to_f2) begin
        o_f2_insn <= f1_insn;
    end
end

endmodule : letc_core_stage_f

//--- letc_core_stage_d.sv
`include "letc_core_defs.svh"

module letc_core_stage_d (
    //Clock and reset
    input  logic                    i_clk,
    input  logic                    i_rst_n,

    //From F2
    input  logic                    i_f2_valid,
    input  letc_core_pkg::word_t    i_f2_insn,

    //Stall and flush from the hazard unit
    input  logic                    i_stall_d,
    input  logic                    i_stall_e1,
    input  logic                    i_flush_e1,

    //Occupancy and register-file read
    output logic                    o_d_valid,
    output letc_core_pkg::reg_idx_t o_rs1_idx,
    output letc_core_pkg::reg_idx_t o_rs2_idx,
    input  letc_core_pkg::word_t    i_rs1_rdata,
    input  letc_core_pkg::word_t    i_rs2_rdata,

    //Bypass overrides
    input  logic                    i_bypass_rs1,
    input  logic                    i_bypass_rs2,
    input  letc_core_pkg::word_t    i_bypass_rs1_rdata,
    input  letc_core_pkg::word_t    i_bypass_rs2_rdata,

    //D/E1 register
    output logic                    o_e1_valid,
    output letc_core_pkg::alu_op_e  o_e1_op,
    output letc_core_pkg::word_t    o_e1_a,
    output letc_core_pkg::word_t    o_e1_b,
    output letc_core_pkg::reg_idx_t o_e1_rd_idx
);

letc_core_pkg::insn_u    d_insn;
letc_core_pkg::alu_op_e  op;
logic                    is_imm;
logic                    supported;
letc_core_pkg::reg_idx_t rd_idx;
letc_core_pkg::word_t    imm_sext;
letc_core_pkg::word_t    opnd_a;
letc_core_pkg::word_t    opnd_b;

//D register
always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
        o_d_valid <= 1'b0;
    end else if (!i_stall_d) begin
        o_d_valid <= i_f2_valid;
    end
end

always_ff @(posedge i_clk) begin
    if (!i_stall_d) begin
        d_insn <= letc_core_pkg::insn_u'(i_f2_insn);
    end
end

//Decode, R-type through r_fmt and ADDI through i_fmt
always_comb begin
    op     = letc_core_pkg::ALU_NONE;
    is_imm = 1'b0;
    case (d_insn.r_fmt.opcode)
        letc_core_pkg::OPC_OP: begin
            case ({d_insn.r_fmt.funct7, d_insn.r_fmt.funct3})
                {letc_core_pkg::F7_BASE, letc_core_pkg::F3_ADD_SUB}: op = letc_core_pkg::ALU_ADD;
                {letc_core_pkg::F7_SUB,  letc_core_pkg::F3_ADD_SUB}: op = letc_core_pkg::ALU_SUB;
                {letc_core_pkg::F7_BASE, letc_core_pkg::F3_AND}:     op = letc_core_pkg::ALU_AND;
                {letc_core_pkg::F7_BASE, letc_core_pkg::F3_OR}:      op = letc_core_pkg::ALU_OR;
                {letc_core_pkg::F7_BASE, letc_core_pkg::F3_XOR}:     op = letc_core_pkg::ALU_XOR;
                default:                                             op = letc_core_pkg::ALU_NONE;
            endcase
        end
        letc_core_pkg::OPC_OP_IMM: begin
            if (d_insn.i_fmt.funct3 == letc_core_pkg::F3_ADD_SUB) begin
                op     = letc_core_pkg::ALU_ADD;
                is_imm = 1'b1;
            end
        end
        default: op = letc_core_pkg::ALU_NONE;
    endcase
end

//Anything else is a no-op that reads and writes nothing
//rs1 sits in the same bits in both layouts
assign supported = o_d_valid && (op != letc_core_pkg::ALU_NONE);
assign o_rs1_idx = supported ? d_insn.r_fmt.rs1 : '0;
assign o_rs2_idx = (supported && !is_imm) ? d_insn.r_fmt.rs2 : '0;
assign rd_idx    = supported ? d_insn.r_fmt.rd : '0;

//Operand select
assign imm_sext = {{(`LETC_XLEN-`LETC_IMM_W){d_insn.i_fmt.imm[`LETC_IMM_W-1]}},
                   d_insn.i_fmt.imm};
assign opnd_a   = i_bypass_rs1 ? i_bypass_rs1_rdata : i_rs1_rdata;
assign opnd_b   = is_imm ? imm_sext : (i_bypass_rs2 ? i_bypass_rs2_rdata : i_rs2_rdata);

//D/E1 register, a flush loads a bubble
always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
        o_e1_valid <= 1'b0;
    end else if (i_flush_e1) begin
        o_e1_valid <= 1'b0;
    end else if (!i_stall_e1) begin
        o_e1_valid <= o_d_valid;
    end
end

always_ff @(posedge i_clk) begin
    if (i_flush_e1) begin
        o_e1_op     <= letc_core_pkg::ALU_NONE;
        o_e1_rd_idx <= '0;
    end else if (!i_stall_e1) begin
        o_e1_op     <= op;
        o_e1_a      <= opnd_a;
        o_e1_b      <= opnd_b;
        o_e1_rd_idx <= rd_idx;
    end
end

endmodule : letc_core_stage_d

//--- letc_core_stage_e1.sv
module letc_core_stage_e1 (
    //Clock and reset
    input  logic                    i_clk,
    input  logic                    i_rst_n,

    //D/E1 register contents
    input  logic                    i_e1_valid,
    input  letc_core_pkg::alu_op_e  i_e1_op,
    input  letc_core_pkg::word_t    i_e1_a,
    input  letc_core_pkg::word_t    i_e1_b,
    input  letc_core_pkg::reg_idx_t i_e1_rd_idx,

    //Stall from the hazard unit
    input  logic                    i_stall_e2,

    //Destination seen by hazard detection
    output letc_core_pkg::reg_idx_t o_e1_rd_idx,

    //E1/E2 register
    output logic                    o_e2_valid,
    output letc_core_pkg::reg_idx_t o_e2_rd_idx,
    output letc_core_pkg::word_t    o_e2_data
);

letc_core_pkg::word_t alu_result;

//Only a valid occupant can cause a hazard
assign o_e1_rd_idx = i_e1_valid ? i_e1_rd_idx : '0;

//ALU
always_comb begin
    case (i_e1_op)
        letc_core_pkg::ALU_ADD: alu_result = i_e1_a + i_e1_b;
        letc_core_pkg::ALU_SUB: alu_result = i_e1_a - i_e1_b;
        letc_core_pkg::ALU_AND: alu_result = i_e1_a & i_e1_b;
        letc_core_pkg::ALU_OR:  alu_result = i_e1_a | i_e1_b;
        letc_core_pkg::ALU_XOR: alu_result = i_e1_a ^ i_e1_b;
        //No-ops carry rd zero so the value never lands anywhere
        default:                alu_result = '0;
    endcase
end

//E1/E2 register
always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
        o_e2_valid <= 1'b0;
    end else if (!i_stall_e2) begin
        o_e2_valid <= i_e1_valid;
    end
end

always_ff @(posedge i_clk) begin
    if (!i_stall_e2) begin
        o_e2_rd_idx <= i_e1_rd_idx;
        o_e2_data   <= alu_result;
    end
end

endmodule : letc_core_stage_e1

//--- letc_core_stage_e2w.sv
module letc_core_stage_e2w (
    //Clock and reset
    input  logic                    i_clk,
    input  logic                    i_rst_n,

    //E1/E2 register contents
    input  logic                    i_e2_valid,
    input  letc_core_pkg::reg_idx_t i_e2_rd_idx,
    input  letc_core_pkg::word_t    i_e2_data,

    //Stall and retire back-pressure
    input  logic                    i_stall_w,
    input  logic                    i_wb_ready,

    //E2 destination for the bypass
    output letc_core_pkg::reg_idx_t o_e2_rd_idx,

    //W register, also the retire port
    output logic                    o_w_valid,
    output letc_core_pkg::reg_idx_t o_w_rd_idx,
    output letc_core_pkg::word_t    o_w_data,

    //Register-file write enable
    output logic                    o_rf_wen
);

letc_core_pkg::reg_idx_t w_rd_idx;

//Invalid occupants never match in the bypass
assign o_e2_rd_idx = i_e2_valid ? i_e2_rd_idx : '0;

//W register
always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
        o_w_valid <= 1'b0;
    end else if (!i_stall_w) begin
        o_w_valid <= i_e2_valid;
    end
end

//Held unchanged while the consumer is not ready
always_ff @(posedge i_clk) begin
    if (!i_stall_w) begin
        w_rd_idx <= i_e2_rd_idx;
        o_w_data <= i_e2_data;
    end
end

assign o_w_rd_idx = o_w_valid ? w_rd_idx : '0;

//Commit to the register file on the retire edge
assign o_rf_wen = o_w_valid && i_wb_ready && (o_w_rd_idx != '0);

endmodule : letc_core_stage_e2w

//--- letc_core.sv
`include "letc_core_defs.svh"

module letc_core (
    //Clock and reset
    input  logic                    i_clk,
    input  logic                    i_rst_n,

    //Instruction input
    input  logic                    i_insn_valid,
    output logic                    o_insn_ready,
    input  letc_core_pkg::word_t    i_insn,

    //Retire port
    output logic                    o_wb_valid,
    input  logic                    i_wb_ready,
    output letc_core_pkg::reg_idx_t o_wb_rd_idx,
    output letc_core_pkg::word_t    o_wb_data
);

//Per-stage vectors
logic [`LETC_NUM_STAGES-1:0] stage_valid;
logic [`LETC_NUM_STAGES-1:0] stage_stall;
logic [`LETC_NUM_STAGES-1:0] stage_flush;

//F to D
logic                    f1_valid;
logic                    f2_valid;
letc_core_pkg::word_t    f2_insn;

//D and register file
logic                    d_valid;
letc_core_pkg::reg_idx_t rs1_idx;
letc_core_pkg::reg_idx_t rs2_idx;
letc_core_pkg::word_t    rs1_rdata;
letc_core_pkg::word_t    rs2_rdata;
logic                    bypass_rs1;
logic                    bypass_rs2;
letc_core_pkg::word_t    bypass_rs1_rdata;
letc_core_pkg::word_t    bypass_rs2_rdata;

//D/E1 register
logic                    e1_valid;
letc_core_pkg::alu_op_e  e1_op;
letc_core_pkg::word_t    e1_a;
letc_core_pkg::word_t    e1_b;
letc_core_pkg::reg_idx_t e1_rd_idx;
letc_core_pkg::reg_idx_t e1_rd_idx_q;

//E2 and W
logic                    e2_valid;
letc_core_pkg::reg_idx_t e2_rd_idx;
letc_core_pkg::reg_idx_t e2_rd_idx_q;
letc_core_pkg::word_t    e2_data;
logic                    rf_wen;

assign stage_valid  = {o_wb_valid, e2_valid, e1_valid, d_valid, f2_valid, f1_valid};
assign o_insn_ready = !stage_stall[letc_core_pkg::STAGE_F1];

letc_core_tghm tghm_i (
    .i_stage_valid(stage_valid),
    .i_wb_ready(i_wb_ready),
    .i_d_rs1_idx(rs1_idx),
    .i_d_rs2_idx(rs2_idx),
    .i_e1_rd_idx(e1_rd_idx_q),
    .i_e2_rd_idx(e2_rd_idx_q),
    .i_w_rd_idx(o_wb_rd_idx),
    .i_e2_rd_data(e2_data),
    .i_w_rd_data(o_wb_data),
    .o_stage_stall(stage_stall),
    .o_stage_flush(stage_flush),
    .o_stage_d_bypass_rs1(bypass_rs1),
    .o_stage_d_bypass_rs2(bypass_rs2),
    .o_stage_d_bypass_rs1_rdata(bypass_rs1_rdata),
    .o_stage_d_bypass_rs2_rdata(bypass_rs2_rdata)
);

letc_core_rf rf_i (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_rs1_idx(rs1_idx),
    .i_rs2_idx(rs2_idx),
    .o_rs1_rdata(rs1_rdata),
    .o_rs2_rdata(rs2_rdata),
    .i_wen(rf_wen),
    .i_rd_idx(o_wb_rd_idx),
    .i_rd_data(o_wb_data)
);

letc_core_stage_f stage_f_i (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_insn_valid(i_insn_valid),
    .i_insn(i_insn),
    .i_stall_f1(stage_stall[letc_core_pkg::STAGE_F1]),
    .i_stall_f2(stage_stall[letc_core_pkg::STAGE_F2]),
    .i_stall_d(stage_stall[letc_core_pkg::STAGE_D]),
    .o_f1_valid(f1_valid),
    .o_f2_valid(f2_valid),
    .o_f2_insn(f2_insn)
);

letc_core_stage_d stage_d_i (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_f2_valid(f2_valid),
    .i_f2_insn(f2_insn),
    .i_stall_d(stage_stall[letc_core_pkg::STAGE_D]),
    .i_stall_e1(stage_stall[letc_core_pkg::STAGE_E1]),
    .i_flush_e1(stage_flush[letc_core_pkg::STAGE_E1]),
    .o_d_valid(d_valid),
    .o_rs1_idx(rs1_idx),
    .o_rs2_idx(rs2_idx),
    .i_rs1_rdata(rs1_rdata),
    .i_rs2_rdata(rs2_rdata),
    .i_bypass_rs1(bypass_rs1),
    .i_bypass_rs2(bypass_rs2),
    .i_bypass_rs1_rdata(bypass_rs1_rdata),
    .i_bypass_rs2_rdata(bypass_rs2_rdata),
    .o_e1_valid(e1_valid),
    .o_e1_op(e1_op),
    .o_e1_a(e1_a),
    .o_e1_b(e1_b),
    .o_e1_rd_idx(e1_rd_idx)
);

letc_core_stage_e1 stage_e1_i (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_e1_valid(e1_valid),
    .i_e1_op(e1_op),
    .i_e1_a(e1_a),
    .i_e1_b(e1_b),
    .i_e1_rd_idx(e1_rd_idx),
    .i_stall_e2(stage_stall[letc_core_pkg::STAGE_E2]),
    .o_e1_rd_idx(e1_rd_idx_q),
    .o_e2_valid(e2_valid),
    .o_e2_rd_idx(e2_rd_idx),
    .o_e2_data(e2_data)
);

letc_core_stage_e2w stage_e2w_i (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_e2_valid(e2_valid),
    .i_e2_rd_idx(e2_rd_idx),
    .i_e2_data(e2_data),
    .i_stall_w(stage_stall[letc_core_pkg::STAGE_W]),
    .i_wb_ready(i_wb_ready),
    .o_e2_rd_idx(e2_rd_idx_q),
    .o_w_valid(o_wb_valid),
    .o_w_rd_idx(o_wb_rd_idx),
    .o_w_data(o_wb_data),
    .o_rf_wen(rf_wen)
);

endmodule : letc_core

//--- letc_core_properties.sv
`include "letc_core_defs.svh"

module letc_core_properties (
    input logic                        i_clk,
    input logic                        i_rst_n,
    input logic                        i_insn_ready,
    input logic                        i_wb_valid,
    input logic                        i_wb_ready,
    input logic [`LETC_REG_IDX_W-1:0]  i_wb_rd_idx,
    input logic [`LETC_XLEN-1:0]       i_wb_data,
    input logic [`LETC_NUM_STAGES-1:0] i_stage_valid
);

//Number of assertion failures, read by the testbench
int fail_cnt;

initial fail_cnt = 0;

//Retire port holds while the consumer stalls it
wb_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_wb_valid && !i_wb_ready) |=>
    (i_wb_valid && $stable(i_wb_rd_idx) && $stable(i_wb_data)))
    else begin
        fail_cnt++;
        $error("retire port changed while held by back-pressure");
    end

//Pipeline comes out of reset empty
reset_empty: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_wb_valid)
    else begin
        fail_cnt++;
        $error("retire valid high in the first cycle after reset");
    end

//Full and blocked pipeline takes nothing in
full_blocks_input: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    ((&i_stage_valid) && !i_wb_ready) |-> !i_insn_ready)
    else begin
        fail_cnt++;
        $error("instruction input ready while all stages are full and W is blocked");
    end

endmodule : letc_core_properties

bind letc_core letc_core_properties props_i (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_insn_ready(o_insn_ready),
    .i_wb_valid(o_wb_valid),
    .i_wb_ready(i_wb_ready),
    .i_wb_rd_idx(o_wb_rd_idx),
    .i_wb_data(o_wb_data),
    .i_stage_valid(stage_valid)
);

//--- tb_letc_core.sv
`include "letc_core_defs.svh"

module tb_clk_gen (
    output logic o_clk
);

//Period of 8
initial o_clk = 1'b0;
always #4 o_clk = ~o_clk;

endmodule : tb_clk_gen

module tb_letc_core;

//ALU kinds used by the encoder
localparam int K_ADD = 0;
localparam int K_SUB = 1;
localparam int K_AND = 2;
localparam int K_OR  = 3;
localparam int K_XOR = 4;

//Directed tests hold 13, 12, 8 and 9 instructions
localparam int N_RANDOM   = 300;
localparam int N_TOTAL    = 13 + 12 + 8 + 9 + N_RANDOM;
localparam int WDOG_CYCLES = N_TOTAL * 20 + 200;

//Longest wait for the pipeline to empty at the end of one test
localparam int DRAIN_CYCLES = 200;

logic                           i_clk;
logic                           i_rst_n;
logic                           i_insn_valid;
logic                           o_insn_ready;
letc_core_pkg::word_t           i_insn;
logic                           o_wb_valid;
logic                           i_wb_ready;
letc_core_pkg::reg_idx_t        o_wb_rd_idx;
letc_core_pkg::word_t           o_wb_data;

//Model state and expected retires
logic [`LETC_XLEN-1:0]          model_regs [0:`LETC_NUM_REGS-1];
logic [`LETC_REG_IDX_W-1:0]     exp_rd [$];
logic [`LETC_XLEN-1:0]          exp_data [$];

logic [31:0] rng;
logic [31:0] wb_rng;
logic        wb_random;
logic        lat_arm;
logic        lat_pending;
int          acc_edge;
int          cyc;
int          n_err;
int          n_chk;
int          n_test;
int          err_mark;
int          chk_mark;

tb_clk_gen clk_gen_i (.o_clk(i_clk));

letc_core letc_core_i (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_insn_valid(i_insn_valid),
    .o_insn_ready(o_insn_ready),
    .i_insn(i_insn),
    .o_wb_valid(o_wb_valid),
    .i_wb_ready(i_wb_ready),
    .o_wb_rd_idx(o_wb_rd_idx),
    .o_wb_data(o_wb_data)
);

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] r_type(input int kind, input int rd, input int rs1,
                                       input int rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = 7'b0000000;
    case (kind)
        K_SUB: begin
            f7 = 7'b0100000;
            f3 = 3'b000;
        end
        K_AND:   f3 = 3'b111;
        K_OR:    f3 = 3'b110;
        K_XOR:   f3 = 3'b100;
        default: f3 = 3'b000;
    endcase
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
endfunction

function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
endfunction

//Expected {rd, value} of one instruction against the model registers
//rd comes back zero for anything that writes nothing
function automatic logic [36:0] ref_result(input logic [31:0] insn);
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic        ok;
    rd  = insn[11:7];
    a   = model_regs[insn[19:15]];
    b   = model_regs[insn[24:20]];
    val = '0;
    ok  = 1'b1;
    if (insn[6:0] == 7'b0110011) begin
        case ({insn[31:25], insn[14:12]})
            {7'b0000000, 3'b000}: val = a + b;
            {7'b0100000, 3'b000}: val = a - b;
            {7'b0000000, 3'b111}: val = a & b;
            {7'b0000000, 3'b110}: val = a | b;
            {7'b0000000, 3'b100}: val = a ^ b;
            default:              ok  = 1'b0;
        endcase
    end else if (insn[6:0] == 7'b0010011 && insn[14:12] == 3'b000) begin
        val = a + {{20{insn[31]}}, insn[31:20]};
    end else begin
        ok = 1'b0;
    end
    if (!ok || rd == 5'd0) begin
        return {5'd0, 32'd0};
    end
    return {rd, val};
endfunction

//Random instruction over x0 to x3, with one custom opcode as a no-op
function automatic logic [31:0] random_insn(input logic [31:0] r);
    case (r[2:0])
        3'd0, 3'd6: return addi_word(int'(r[4:3]), int'(r[6:5]), int'(r[20:9]));
        3'd7:       return {r[31:7], 7'b0001011};
        default:    return r_type(int'(r[2:0]) - 1, int'(r[4:3]), int'(r[6:5]),
                                  int'(r[8:7]));
    endcase
endfunction

task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    n_chk++;
    if (got !== exp) begin
        n_err++;
        $display("ERR %0t: %s mismatch, got 0x%08h expected 0x%08h", $time, what, got, exp);
    end
endtask

//Hold the instruction until the DUT takes it, then run the model
task automatic send_insn(input logic [31:0] insn);
    logic        accepted;
    logic [36:0] res;
    accepted     = 1'b0;
    i_insn       = insn;
    i_insn_valid = 1'b1;
    while (!accepted) begin
        @(negedge i_clk);
        if (o_insn_ready) begin
            accepted = 1'b1;
            res      = ref_result(insn);
            if (res[36:32] != 5'd0) begin
                model_regs[res[36:32]] = res[31:0];
            end
            exp_rd.push_back(res[36:32]);
            exp_data.push_back(res[31:0]);
            if (lat_arm) begin
                acc_edge    = cyc + 1;
                lat_arm     = 1'b0;
                lat_pending = 1'b1;
            end
        end
        @(posedge i_clk);
        #1;
    end
    i_insn_valid = 1'b0;
endtask

task automatic idle_cycle();
    i_insn_valid = 1'b0;
    @(posedge i_clk);
    #1;
endtask

//Wait for every expected retire, up to a bounded number of cycles
task automatic drain();
    int waited;
    waited = 0;
    while (exp_rd.size() != 0 && waited < DRAIN_CYCLES) begin
        @(posedge i_clk);
        waited++;
    end
    repeat (2) @(posedge i_clk);
    #1;
endtask

task automatic finish_test(input string name);
    n_test++;
    $display("test %0d %s: %0d checks, %0d errors", n_test, name, n_chk - chk_mark,
             n_err - err_mark);
    chk_mark = n_chk;
    err_mark = n_err;
endtask

always @(posedge i_clk) begin
    cyc <= cyc + 1;
end

//Back-pressure on the retire port, random only in the stream test
initial begin
    i_wb_ready = 1'b1;
    wb_rng     = 32'd11421 ^ 32'h9e3779b9;
    forever begin
        @(posedge i_clk);
        #1;
        if (wb_random) begin
            wb_rng     = xorshift32(wb_rng);
            i_wb_ready = wb_rng[4];
        end else begin
            i_wb_ready = 1'b1;
        end
    end
end

//Compare every retire against the queue head
always @(negedge i_clk) begin
    if (i_rst_n && o_wb_valid) begin
        if (lat_pending) begin
            check_eq(32'(cyc - acc_edge), 32'd5, "first retire latency in cycles");
            lat_pending = 1'b0;
        end
        if (i_wb_ready) begin
            if (exp_rd.size() == 0) begin
                n_err++;
                $display("unexpected retire at time %0t with no instruction pending", $time);
            end else begin
                check_eq(32'(o_wb_rd_idx), 32'(exp_rd[0]), "retire rd index");
                if (exp_rd[0] != 5'd0) begin
                    check_eq(o_wb_data, exp_data[0], "retire data");
                end
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end
end

//Watchdog
initial begin
    repeat (WDOG_CYCLES) @(posedge i_clk);
    $display("timeout after %0d cycles, %0d expected retires never arrived",
             WDOG_CYCLES, exp_rd.size());
    $display("TEST FAILED");
    $finish;
end

initial begin
    i_rst_n      = 1'b0;
    i_insn_valid = 1'b0;
    i_insn       = '0;
    wb_random    = 1'b0;
    lat_arm      = 1'b0;
    lat_pending  = 1'b0;
    rng          = 32'd11421;
    cyc          = 0;
    n_err        = 0;
    n_chk        = 0;
    n_test       = 0;
    err_mark     = 0;
    chk_mark     = 0;
    for (int ii = 0; ii < `LETC_NUM_REGS; ++ii) begin
        model_regs[ii] = '0;
    end
    repeat (5) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    @(posedge i_clk);
    #1;

    //Independent instructions, first one also checks latency
    lat_arm = 1'b1;
    for (int ii = 1; ii <= 8; ++ii) begin
        send_insn(addi_word(ii, 0, ii * 37 - 100));
    end
    send_insn(r_type(K_ADD, 9, 1, 2));
    send_insn(r_type(K_SUB, 10, 3, 4));
    send_insn(r_type(K_AND, 11, 5, 6));
    send_insn(r_type(K_OR, 12, 7, 8));
    send_insn(r_type(K_XOR, 13, 1, 8));
    drain();
    finish_test("independent");

    //Back-to-back chains through the E1 bubble and both bypass paths
    send_insn(addi_word(5, 0, 7));
    send_insn(r_type(K_ADD, 5, 5, 5));
    send_insn(r_type(K_SUB, 6, 5, 1));
    send_insn(r_type(K_XOR, 7, 6, 5));
    send_insn(r_type(K_OR, 8, 7, 6));
    send_insn(r_type(K_AND, 9, 8, 7));
    send_insn(addi_word(9, 9, -1));
    send_insn(r_type(K_ADD, 10, 9, 9));
    send_insn(addi_word(11, 0, 100));
    send_insn(addi_word(12, 0, 5));
    send_insn(r_type(K_ADD, 13, 11, 12));
    send_insn(r_type(K_SUB, 14, 13, 11));
    drain();
    finish_test("dependent chains");

    //Negative immediates and x0
    send_insn(addi_word(1, 0, -1));
    send_insn(addi_word(0, 1, 5));
    send_insn(r_type(K_ADD, 2, 0, 1));
    send_insn(addi_word(3, 0, -2048));
    send_insn(r_type(K_SUB, 0, 3, 3));
    send_insn(r_type(K_ADD, 4, 0, 0));
    send_insn(addi_word(5, 3, 2047));
    send_insn(r_type(K_XOR, 6, 5, 0));
    drain();
    finish_test("addi and x0");

    //Load, MUL, SLLI and junk words all retire as no-ops
    send_insn(addi_word(1, 0, 10));
    send_insn({12'd0, 5'd0, 3'b010, 5'd1, 7'b0000011});
    send_insn(r_type(K_ADD, 2, 1, 1));
    send_insn({7'b0000001, 5'd1, 5'd1, 3'b000, 5'd1, 7'b0110011});
    send_insn(addi_word(3, 1, 1));
    send_insn({12'd3, 5'd1, 3'b001, 5'd4, 7'b0010011});
    send_insn(32'h0000_0000);
    send_insn(32'hffff_ffff);
    send_insn(r_type(K_XOR, 5, 1, 3));
    drain();
    finish_test("unsupported encodings");

    //Random stream with random back-pressure and input gaps
    wb_random = 1'b1;
    for (int ii = 0; ii < N_RANDOM; ++ii) begin
        rng = xorshift32(rng);
        if (rng[31:30] == 2'b00) begin
            idle_cycle();
        end
        rng = xorshift32(rng);
        send_insn(random_insn(rng));
    end
    drain();
    wb_random = 1'b0;
    finish_test("random stream");

    if (exp_rd.size() != 0) begin
        n_err++;
        $display("%0d expected retires still pending at the end", exp_rd.size());
    end
    n_err = n_err + letc_core_i.props_i.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d", n_test, n_chk,
             n_err, letc_core_i.props_i.fail_cnt);
    if (n_err == 0) begin
        $display("TEST OK");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule : tb_letc_core

//--- all.f
+incdir+.
letc_core_pkg.sv
letc_core_rf.sv
letc_core_tghm.sv
letc_core_stage_f.sv
letc_core_stage_d.sv
letc_core_stage_e1.sv
letc_core_stage_e2w.sv
letc_core.sv
letc_core_properties.sv
tb_letc_core.sv

//--- Makefile
# Verilator build and run for the letc_core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_letc_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# The log decides pass or fail, not the exit code of the simulator
run: compile
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
